// File: source/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
// 128 sets x 2 ways x 16 words x 4 bytes = 16 KB

// number of sets, one index value each
`define ICACHE_SETS 128

// ways per set
`define ICACHE_WAYS 2

// words in one cache line
`define ICACHE_LINE_WORDS 16

// bus widths

// one instruction word
`define ICACHE_WORD_BITS 32

// byte address on the fetch and burst ports
`define ICACHE_ADDR_BITS 32

`endif

// File: source/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    // address split, derived from the geometry
    localparam int BYTE_BITS = $clog2(`ICACHE_WORD_BITS / 8);
    localparam int OFFSET_BITS = $clog2(`ICACHE_LINE_WORDS);
    localparam int INDEX_BITS = $clog2(`ICACHE_SETS);
    localparam int WAY_BITS = $clog2(`ICACHE_WAYS);
    localparam int TAG_BITS = `ICACHE_ADDR_BITS - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    localparam int OFFSET_LSB = BYTE_BITS;
    localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
    localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;

    typedef logic [`ICACHE_WORD_BITS-1:0] word_t;
    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [WAY_BITS-1:0] way_t;
    // {way, index, offset}
    typedef logic [WAY_BITS+INDEX_BITS+OFFSET_BITS-1:0] ram_addr_t;
    // fetch_2 word in the upper half
    typedef logic [2*`ICACHE_WORD_BITS-1:0] word_pair_t;

    typedef struct packed {
        logic valid;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic addr_ok;
        logic data_ok;
        word_pair_t data;
    } fetch_resp_t;

    typedef struct packed {
        logic valid;
        addr_t addr;
    } burst_req_t;

    typedef struct packed {
        logic ready;
        logic last;
        word_t data;
    } burst_resp_t;

    // stage record, held while a miss is served
    typedef struct packed {
        fetch_req_t fetch_1;
        fetch_req_t fetch_2;
        logic hit_1;
        logic hit_2;
        way_t hit_way_1;
        way_t hit_way_2;
        logic same_line;
    } lookup_t;

    typedef enum logic [1:0] {
        idle,
        fetch_1,
        fetch_2
    } refill_state_t;

endpackage

// File: source/icache_meta_store.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_meta_store (
    input  logic              clk,
    input  logic              resetn,
    input  icache_pkg::index_t rd_index_1,
    input  icache_pkg::index_t rd_index_2,
    input  icache_pkg::tag_t   tag_1,
    input  icache_pkg::tag_t   tag_2,
    output logic              hit_1,
    output logic              hit_2,
    output icache_pkg::way_t   hit_way_1,
    output icache_pkg::way_t   hit_way_2,
    input  logic              wr_en,
    input  icache_pkg::index_t wr_index,
    input  icache_pkg::way_t   wr_way,
    input  icache_pkg::tag_t   wr_tag
);

    icache_pkg::tag_t tags [`ICACHE_WAYS][`ICACHE_SETS];
    logic [`ICACHE_WAYS-1:0][`ICACHE_SETS-1:0] valid;

    logic [`ICACHE_WAYS-1:0] match_1;
    logic [`ICACHE_WAYS-1:0] match_2;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_way][wr_index] <= wr_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[wr_way][wr_index] <= 1'b1;
        end
    end

    // both fetches against every way
    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            match_1[w] = valid[w][rd_index_1] && (tags[w][rd_index_1] == tag_1);
            match_2[w] = valid[w][rd_index_2] && (tags[w][rd_index_2] == tag_2);
        end
    end

    assign hit_1 = |match_1;
    assign hit_2 = |match_2;

    // a tag lives in one way only, so at most one bit is set
    always_comb begin
        hit_way_1 = '0;
        hit_way_2 = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (match_1[w]) begin
                hit_way_1 = icache_pkg::way_t'(w);
            end
            if (match_2[w]) begin
                hit_way_2 = icache_pkg::way_t'(w);
            end
        end
    end

endmodule

// File: source/icache_plru.sv
`timescale 1ns/1ns

module icache_plru (
    input  logic                clk,
    input  logic                resetn,
    input  icache_pkg::lookup_t stage,
    output icache_pkg::way_t    victim_1,
    output icache_pkg::way_t    victim_2,
    input  logic                touch_1,
    input  logic                touch_2,
    input  logic                fill_1,
    input  logic                fill_2
);

    // one bit per set, names the least recent way
    logic [(1 << icache_pkg::INDEX_BITS)-1:0] lru;

    icache_pkg::index_t idx_1;
    icache_pkg::index_t idx_2;
    logic same_set;

    assign idx_1 = stage.fetch_1.addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    assign idx_2 = stage.fetch_2.addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    assign same_set = (idx_1 == idx_2);

    // never evict the way the other fetch hits
    assign victim_1 = (same_set && stage.fetch_2.valid && stage.hit_2) ?
                      ~stage.hit_way_2 : lru[idx_1];
    assign victim_2 = (same_set && stage.hit_1) ? ~stage.hit_way_1 : lru[idx_2];

    always_ff @(posedge clk) begin
        if (resetn) begin
            lru <= '0;
        end else begin
            if (touch_1) begin
                lru[idx_1] <= ~stage.hit_way_1;
            end
            if (fill_1) begin
                lru[idx_1] <= ~victim_1;
            end
            // fetch_2 last, so it ends up most recent
            if (touch_2) begin
                lru[idx_2] <= ~stage.hit_way_2;
            end
            if (fill_2) begin
                lru[idx_2] <= ~victim_2;
            end
        end
    end

endmodule

// File: source/icache_data_ram.sv
`timescale 1ns/1ns

module icache_data_ram (
    input  logic                  clk,
    input  logic                  rd_en,
    input  icache_pkg::ram_addr_t rd_addr,
    output icache_pkg::word_t     rd_data,
    input  logic                  port_en,
    input  logic                  port_we,
    input  icache_pkg::ram_addr_t port_addr,
    input  icache_pkg::word_t     port_wdata,
    output icache_pkg::word_t     port_rdata
);

    localparam int DEPTH = 1 << $bits(icache_pkg::ram_addr_t);

    icache_pkg::word_t mem [DEPTH];

    // port 1, fetch_1 reads only
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // port 2, refill writes or fetch_2 reads
    always_ff @(posedge clk) begin
        if (port_en) begin
            if (port_we) begin
                mem[port_addr] <= port_wdata;
            end else begin
                port_rdata <= mem[port_addr];
            end
        end
    end

endmodule

// File: source/icache_lookup_stage.sv
`timescale 1ns/1ns

module icache_lookup_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  icache_pkg::fetch_req_t fetch_1,
    input  icache_pkg::fetch_req_t fetch_2,
    input  logic                   hit_1,
    input  logic                   hit_2,
    input  icache_pkg::way_t       hit_way_1,
    input  icache_pkg::way_t       hit_way_2,
    input  logic                   refill_done,
    output icache_pkg::lookup_t    stage,
    output logic                   addr_ok,
    output logic                   data_ok,
    output logic                   rd_go
);

    logic accept;
    logic all_hit;
    logic same_line;
    logic busy;
    logic hit_rd;
    logic refill_rd;

    assign accept = ~busy && fetch_1.valid;

    // unwanted fetch_2 counts as a hit
    assign all_hit = hit_1 && (hit_2 || ~fetch_2.valid);

    // tag and index equal, so one burst covers both
    assign same_line = fetch_2.valid &&
                       ((fetch_1.addr >> icache_pkg::INDEX_LSB) ==
                        (fetch_2.addr >> icache_pkg::INDEX_LSB));

    always_ff @(posedge clk) begin
        if (accept) begin
            stage.fetch_1 <= fetch_1;
            stage.fetch_2 <= fetch_2;
            stage.hit_1 <= hit_1;
            stage.hit_2 <= hit_2;
            stage.hit_way_1 <= hit_way_1;
            stage.hit_way_2 <= hit_way_2;
            stage.same_line <= same_line;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy <= 1'b0;
            hit_rd <= 1'b0;
            refill_rd <= 1'b0;
            data_ok <= 1'b0;
        end else begin
            if (accept && ~all_hit) begin
                busy <= 1'b1;
            end else if (refill_rd) begin
                // reopen together with data_ok
                busy <= 1'b0;
            end
            hit_rd <= accept && all_hit;
            refill_rd <= refill_done;
            data_ok <= rd_go;
        end
    end

    assign addr_ok = ~busy;
    assign rd_go = hit_rd || refill_rd;

endmodule

// File: source/icache_refill_fsm.sv
`timescale 1ns/1ns

module icache_refill_fsm (
    input  logic                    clk,
    input  logic                    resetn,
    input  icache_pkg::lookup_t     stage,
    input  logic                    refill_go,
    input  icache_pkg::way_t        victim_1,
    input  icache_pkg::way_t        victim_2,
    output icache_pkg::burst_req_t  mem_req,
    input  icache_pkg::burst_resp_t mem_resp,
    output logic                    meta_wr_en,
    output icache_pkg::index_t      meta_wr_index,
    output icache_pkg::way_t        meta_wr_way,
    output icache_pkg::tag_t        meta_wr_tag,
    output logic                    ram_we,
    output icache_pkg::ram_addr_t   ram_addr,
    output icache_pkg::word_t       ram_wdata,
    output logic                    fill_1,
    output logic                    fill_2,
    output logic                    refill_done,
    output icache_pkg::way_t        fill_way_1,
    output icache_pkg::way_t        fill_way_2
);

    icache_pkg::refill_state_t state;

    logic need_1;
    logic need_2;
    logic done_1;
    logic done_2;
    logic start_1;
    logic start_2;
    logic beat;

    icache_pkg::addr_t miss_addr;
    icache_pkg::index_t miss_index;
    icache_pkg::way_t cur_way;
    icache_pkg::offset_t ptr;

    assign need_1 = ~stage.hit_1;
    assign need_2 = stage.fetch_2.valid && ~stage.hit_2 && ~stage.same_line;

    // done flags keep a finished burst from running twice
    assign start_1 = (state == icache_pkg::idle) && refill_go && need_1 && ~done_1;
    assign start_2 = (state == icache_pkg::idle) && refill_go && ~start_1 &&
                     need_2 && ~done_2;

    assign miss_addr = (state == icache_pkg::fetch_2) ? stage.fetch_2.addr :
                       stage.fetch_1.addr;
    assign miss_index = miss_addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS];
    assign cur_way = (state == icache_pkg::fetch_2) ? fill_way_2 : fill_way_1;

    assign beat = (state != icache_pkg::idle) && mem_resp.ready;
    assign fill_1 = (state == icache_pkg::fetch_1) && beat && mem_resp.last;
    assign fill_2 = (state == icache_pkg::fetch_2) && beat && mem_resp.last;
    assign refill_done = (fill_1 && ~need_2) || fill_2;

    assign mem_req.valid = (state != icache_pkg::idle);
    assign mem_req.addr = miss_addr;

    // one word per ready beat
    assign ram_we = beat;
    assign ram_addr = {cur_way, miss_index, ptr};
    assign ram_wdata = mem_resp.data;

    assign meta_wr_en = fill_1 || fill_2;
    assign meta_wr_index = miss_index;
    assign meta_wr_way = cur_way;
    assign meta_wr_tag = miss_addr[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS];

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= icache_pkg::idle;
            done_1 <= 1'b0;
            done_2 <= 1'b0;
        end else begin
            unique case (state)
                icache_pkg::idle: begin
                    if (start_1) begin
                        state <= icache_pkg::fetch_1;
                    end else if (start_2) begin
                        state <= icache_pkg::fetch_2;
                    end
                end
                icache_pkg::fetch_1: begin
                    if (fill_1) begin
                        state <= icache_pkg::idle;
                    end
                end
                icache_pkg::fetch_2: begin
                    if (fill_2) begin
                        state <= icache_pkg::idle;
                    end
                end
                default: begin
                    state <= icache_pkg::idle;
                end
            endcase
            // cleared once the stage accepts again
            if (~refill_go) begin
                done_1 <= 1'b0;
                done_2 <= 1'b0;
            end else begin
                if (fill_1) begin
                    done_1 <= 1'b1;
                end
                if (fill_2) begin
                    done_2 <= 1'b1;
                end
            end
        end
    end

    // burst start latches the victim and the missed word
    always_ff @(posedge clk) begin
        if (start_1) begin
            ptr <= stage.fetch_1.addr[icache_pkg::OFFSET_LSB +: icache_pkg::OFFSET_BITS];
            fill_way_1 <= victim_1;
            if (stage.same_line) begin
                fill_way_2 <= victim_1;
            end
        end else if (start_2) begin
            ptr <= stage.fetch_2.addr[icache_pkg::OFFSET_LSB +: icache_pkg::OFFSET_BITS];
            fill_way_2 <= victim_2;
        end else if (beat) begin
            // wraps within the line
            ptr <= ptr + 1'b1;
        end
    end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ns

module icache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  icache_pkg::fetch_req_t  fetch_1,
    input  icache_pkg::fetch_req_t  fetch_2,
    output icache_pkg::fetch_resp_t resp,
    output icache_pkg::burst_req_t  mem_req,
    input  icache_pkg::burst_resp_t mem_resp
);

    logic hit_1;
    logic hit_2;
    icache_pkg::way_t hit_way_1;
    icache_pkg::way_t hit_way_2;
    icache_pkg::lookup_t stage;
    logic addr_ok;
    logic data_ok;
    logic rd_go;
    logic refill_done;
    icache_pkg::way_t victim_1;
    icache_pkg::way_t victim_2;
    logic fill_1;
    logic fill_2;
    logic touch_1;
    logic touch_2;
    logic meta_wr_en;
    icache_pkg::index_t meta_wr_index;
    icache_pkg::way_t meta_wr_way;
    icache_pkg::tag_t meta_wr_tag;
    logic ram_we;
    icache_pkg::ram_addr_t ram_addr;
    icache_pkg::word_t ram_wdata;
    icache_pkg::way_t fill_way_1;
    icache_pkg::way_t fill_way_2;
    icache_pkg::way_t rd_way_1;
    icache_pkg::way_t rd_way_2;
    icache_pkg::ram_addr_t rd_addr_1;
    icache_pkg::ram_addr_t rd_addr_2;
    icache_pkg::word_t word_1;
    icache_pkg::word_t word_2;

    icache_meta_store u_meta (
        .clk, .resetn,
        .rd_index_1(fetch_1.addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS]),
        .rd_index_2(fetch_2.addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS]),
        .tag_1(fetch_1.addr[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS]),
        .tag_2(fetch_2.addr[icache_pkg::TAG_LSB +: icache_pkg::TAG_BITS]),
        .hit_1, .hit_2, .hit_way_1, .hit_way_2,
        .wr_en(meta_wr_en), .wr_index(meta_wr_index),
        .wr_way(meta_wr_way), .wr_tag(meta_wr_tag)
    );

    icache_lookup_stage u_stage (
        .clk, .resetn, .fetch_1, .fetch_2,
        .hit_1, .hit_2, .hit_way_1, .hit_way_2,
        .refill_done, .stage, .addr_ok, .data_ok, .rd_go
    );

    // hit ways count once, at the single read of each request
    assign touch_1 = rd_go && stage.hit_1;
    assign touch_2 = rd_go && stage.fetch_2.valid && stage.hit_2;

    icache_plru u_plru (
        .clk, .resetn, .stage, .victim_1, .victim_2,
        .touch_1, .touch_2, .fill_1, .fill_2
    );

    icache_refill_fsm u_refill (
        .clk, .resetn, .stage,
        .refill_go(~addr_ok),
        .victim_1, .victim_2, .mem_req, .mem_resp,
        .meta_wr_en, .meta_wr_index, .meta_wr_way, .meta_wr_tag,
        .ram_we, .ram_addr, .ram_wdata,
        .fill_1, .fill_2, .refill_done, .fill_way_1, .fill_way_2
    );

    // missed fetches read from the line just filled
    assign rd_way_1 = stage.hit_1 ? stage.hit_way_1 : fill_way_1;
    assign rd_way_2 = stage.hit_2 ? stage.hit_way_2 : fill_way_2;
    assign rd_addr_1 = {rd_way_1,
                        stage.fetch_1.addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS],
                        stage.fetch_1.addr[icache_pkg::OFFSET_LSB +: icache_pkg::OFFSET_BITS]};
    assign rd_addr_2 = {rd_way_2,
                        stage.fetch_2.addr[icache_pkg::INDEX_LSB +: icache_pkg::INDEX_BITS],
                        stage.fetch_2.addr[icache_pkg::OFFSET_LSB +: icache_pkg::OFFSET_BITS]};

    icache_data_ram u_ram (
        .clk,
        .rd_en(rd_go), .rd_addr(rd_addr_1), .rd_data(word_1),
        .port_en(rd_go || ram_we), .port_we(ram_we),
        .port_addr(ram_we ? ram_addr : rd_addr_2),
        .port_wdata(ram_wdata), .port_rdata(word_2)
    );

    assign resp.addr_ok = addr_ok;
    assign resp.data_ok = data_ok;
    assign resp.data = {word_2, word_1};

endmodule

// File: tb/icache_assertions.sv
`timescale 1ns/1ns

module icache_assertions (
    input logic                    clk,
    input logic                    resetn,
    input icache_pkg::fetch_resp_t resp,
    input icache_pkg::burst_req_t  mem_req
);

    int unsigned fail_count = 0;

    // bursts only run while the stage holds a miss
    no_burst_while_open: assert property (
        @(posedge clk) disable iff (resetn) !(mem_req.valid && resp.addr_ok)
    ) else begin
        $error("mem_req.valid high while resp.addr_ok high");
        fail_count++;
    end

    burst_addr_stable: assert property (
        @(posedge clk) disable iff (resetn)
        mem_req.valid |=> (!mem_req.valid || $stable(mem_req.addr))
    ) else begin
        $error("mem_req.addr changed during a burst");
        fail_count++;
    end

    data_ok_single: assert property (
        @(posedge clk) disable iff (resetn) resp.data_ok |=> !resp.data_ok
    ) else begin
        $error("resp.data_ok high two cycles in a row");
        fail_count++;
    end

endmodule

bind icache_top icache_assertions u_assertions (.clk, .resetn, .resp, .mem_req);

// File: tb/icache_tb.sv
`timescale 1ns/1ns
`include "icache_settings.svh"

module icache_tb;

    // 8 bursts over all tests
    // slowest ready rate is one beat in four
    localparam int BURSTS = 8;
    localparam int BEAT_CYCLES = 4;
    localparam int CYCLE_LIMIT = 10 * BURSTS * `ICACHE_LINE_WORDS * BEAT_CYCLES;

    localparam icache_pkg::addr_t PAIR_A1 = 32'h0001_2048;
    localparam icache_pkg::addr_t PAIR_A2 = 32'h0002_40c4;
    localparam icache_pkg::addr_t LINE_A1 = 32'h0000_33f8;
    localparam icache_pkg::addr_t LINE_A2 = 32'h0000_33c4;
    localparam icache_pkg::addr_t SET_A = 32'h0010_0804;
    localparam icache_pkg::addr_t SET_B = 32'h0020_0808;
    localparam icache_pkg::addr_t SET_C = 32'h0030_080c;
    localparam icache_pkg::addr_t SLOW_A = 32'h0040_1f5c;

    logic clk;
    logic resetn;
    icache_pkg::fetch_req_t fetch_1;
    icache_pkg::fetch_req_t fetch_2;
    icache_pkg::fetch_resp_t resp;
    icache_pkg::burst_req_t mem_req;
    icache_pkg::burst_resp_t mem_resp;

    integer seed;
    int cycles;
    int errors;
    int tests;
    int failed_tests;
    int burst_count;
    int beat_cnt;
    logic sparse;

    icache_top u_dut (
        .clk, .resetn, .fetch_1, .fetch_2, .resp, .mem_req, .mem_resp
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic icache_pkg::word_t model_word(input icache_pkg::addr_t a);
        return {a[31:2], 2'b00} ^ 32'hc0de_0000;
    endfunction

    // k-th beat of a burst, wrapping within the line
    function automatic icache_pkg::addr_t beat_addr(input icache_pkg::addr_t start,
                                                    input int k);
        icache_pkg::offset_t off;
        off = start[5:2] + k[3:0];
        return {start[31:6], off, 2'b00};
    endfunction

    // memory model
    initial begin
        mem_resp = '0;
        beat_cnt = 0;
        burst_count = 0;
        forever begin
            @(posedge clk);
            #1;
            // a beat driven last cycle was taken at this edge
            if (mem_resp.ready) begin
                if (mem_resp.last) begin
                    beat_cnt = 0;
                    burst_count++;
                end else begin
                    beat_cnt++;
                end
            end
            mem_resp = '0;
            if (mem_req.valid === 1'b1) begin
                mem_resp.ready = sparse ? (($random(seed) & 3) == 0) :
                                          (($random(seed) & 3) != 0);
                if (mem_resp.ready) begin
                    mem_resp.last = (beat_cnt == `ICACHE_LINE_WORDS - 1);
                    mem_resp.data = model_word(beat_addr(mem_req.addr, beat_cnt));
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT never finished the tests", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic compare_pair(input string name, input icache_pkg::word_pair_t got,
                                input icache_pkg::word_pair_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input icache_pkg::word_t got,
                                input icache_pkg::word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("** Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - start_errors);
        end
    endtask

    // called and returns 1 ns after a rising edge
    task automatic run_request(input icache_pkg::addr_t a1, input logic want_2,
                               input icache_pkg::addr_t a2,
                               output icache_pkg::word_pair_t data, output int latency,
                               output int bursts, output int pulses);
        int start_bursts;
        start_bursts = burst_count;
        fetch_1 = '{valid: 1'b1, addr: a1};
        fetch_2 = '{valid: want_2, addr: a2};
        while (resp.addr_ok !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        // accepted at this edge
        @(posedge clk);
        #1;
        fetch_1.valid = 1'b0;
        fetch_2.valid = 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            #1;
            latency++;
        end while (resp.data_ok !== 1'b1);
        data = resp.data;
        pulses = 1;
        repeat (3) begin
            @(posedge clk);
            #1;
            if (resp.data_ok === 1'b1) begin
                pulses++;
            end
        end
        bursts = burst_count - start_bursts;
    endtask

    task automatic pair_request(input icache_pkg::addr_t a1, input icache_pkg::addr_t a2,
                                input int exp_bursts, input int exp_latency);
        icache_pkg::word_pair_t data;
        int latency;
        int bursts;
        int pulses;
        run_request(a1, 1'b1, a2, data, latency, bursts, pulses);
        compare_pair("resp.data", data, {model_word(a2), model_word(a1)});
        compare_count("burst count", bursts, exp_bursts);
        compare_count("data_ok pulses", pulses, 1);
        if (exp_latency > 0) begin
            compare_count("data_ok latency", latency, exp_latency);
        end
    endtask

    task automatic single_request(input icache_pkg::addr_t a1, input int exp_bursts);
        icache_pkg::word_pair_t data;
        int latency;
        int bursts;
        int pulses;
        run_request(a1, 1'b0, '0, data, latency, bursts, pulses);
        compare_word("resp.data lower", data[31:0], model_word(a1));
        compare_count("burst count", bursts, exp_bursts);
        compare_count("data_ok pulses", pulses, 1);
    endtask

    task automatic cold_pair_misses();
        int start_errors;
        start_errors = errors;
        compare_bit("resp.addr_ok", resp.addr_ok, 1'b1);
        compare_bit("mem_req.valid", mem_req.valid, 1'b0);
        pair_request(PAIR_A1, PAIR_A2, 2, 0);
        report_test("cold pair, two lines", start_errors);
    endtask

    task automatic repeated_pair_hits();
        int start_errors;
        start_errors = errors;
        pair_request(PAIR_A1, PAIR_A2, 0, 1);
        report_test("repeated pair hits", start_errors);
    endtask

    task automatic same_line_one_burst();
        int start_errors;
        start_errors = errors;
        // start offset 14 wraps to the line start
        pair_request(LINE_A1, LINE_A2, 1, 0);
        report_test("same line, one burst", start_errors);
    endtask

    task automatic lru_eviction();
        int start_errors;
        start_errors = errors;
        single_request(SET_A, 1);
        single_request(SET_B, 1);
        single_request(SET_A, 0);
        // B is now least recent
        single_request(SET_C, 1);
        single_request(SET_A, 0);
        single_request(SET_B, 1);
        report_test("pseudo-LRU replacement", start_errors);
    endtask

    task automatic sparse_ready_single();
        int start_errors;
        start_errors = errors;
        sparse = 1'b1;
        single_request(SLOW_A, 1);
        sparse = 1'b0;
        report_test("single fetch, sparse ready", start_errors);
    endtask

    initial begin
        seed = 62302;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        sparse = 1'b0;
        resetn = 1'b1;
        fetch_1 = '0;
        fetch_2 = '0;
        repeat (3) begin
            @(posedge clk);
        end
        #1;
        resetn = 1'b0;
        cold_pair_misses();
        repeated_pair_hits();
        same_line_one_burst();
        lru_eviction();
        sparse_ready_single();
        errors = errors + u_dut.u_assertions.fail_count;
        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+source
source/icache_pkg.sv
source/icache_meta_store.sv
source/icache_plru.sv
source/icache_data_ram.sv
source/icache_lookup_stage.sv
source/icache_refill_fsm.sv
source/icache_top.sv
tb/icache_assertions.sv
tb/icache_tb.sv
